/* common/ocd_pkg.sv */
// shared widths, frame layout, type codes and bus structs, used by scoped name from RTL and testbench
`default_nettype none

package ocd_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // widths
    ////////////////////////////////////////////////////////////////////////////

    localparam int DATA_WIDTH = 8;
    localparam int ADDR_WIDTH = 16;
    localparam int WORD_WIDTH = 32;
    localparam int PC_WIDTH   = 16;

    ////////////////////////////////////////////////////////////////////////////
    // frame layout
    ////////////////////////////////////////////////////////////////////////////

    // first byte on the wire sits in the top bits
    localparam int SYNC_LEN  = 3;
    localparam int FRAME_LEN = 12;
    localparam logic [DATA_WIDTH*SYNC_LEN-1:0] SYNC_PATTERN = 24'h5AA596;

    // CCITT, MSB first, no reflection; residue over a good frame is zero
    localparam logic [15:0] CRC_INIT = 16'hFFFF;
    localparam logic [15:0] CRC_POLY = 16'h1021;

    // frame type codes, upper seven bits of the type byte
    localparam int TYPE_WIDTH = 7;
    localparam logic [TYPE_WIDTH-1:0] FT_PRAM_WRITE_NOACK = 7'd1;
    localparam logic [TYPE_WIDTH-1:0] FT_PRAM_WRITE_ACK   = 7'd2;
    localparam logic [TYPE_WIDTH-1:0] FT_PRAM_READ        = 7'd3;
    localparam logic [TYPE_WIDTH-1:0] FT_PAUSE_ON         = 7'd4;
    localparam logic [TYPE_WIDTH-1:0] FT_PAUSE_OFF        = 7'd5;
    localparam logic [TYPE_WIDTH-1:0] FT_BREAK_ON         = 7'd6;
    localparam logic [TYPE_WIDTH-1:0] FT_BREAK_OFF        = 7'd7;
    localparam logic [TYPE_WIDTH-1:0] FT_RUN_PULSE        = 7'd8;
    localparam logic [TYPE_WIDTH-1:0] FT_READ_STATUS      = 7'd9;

    // reply opcode bit positions, one hot
    localparam int OP_ACK       = 0;
    localparam int OP_READ_BACK = 1;
    localparam int OP_STATUS    = 2;
    localparam int NUM_OPS      = 3;

    localparam logic [WORD_WIDTH-1:0] ACK_SIGNATURE = 32'hAAABACAD;

    ////////////////////////////////////////////////////////////////////////////
    // structs
    ////////////////////////////////////////////////////////////////////////////

    typedef logic [NUM_OPS-1:0] op_t;

    typedef struct packed {
        logic [TYPE_WIDTH-1:0] frame_type;
        logic                  toggle;
        logic [ADDR_WIDTH-1:0] addr;
        logic [WORD_WIDTH-1:0] data;
    } frame_t;

    typedef struct packed {
        op_t    op;
        frame_t payload;
    } reply_t;

    // one-cycle strobes towards the CPU control block
    typedef struct packed {
        logic                pause_on;
        logic                pause_off;
        logic                break_on;
        logic                break_off;
        logic                run;
        logic [PC_WIDTH-1:0] break_a;
        logic [PC_WIDTH-1:0] break_b;
    } cpu_cmd_t;

endpackage

`default_nettype wire

/* frame_rx/ocd_crc16.sv */
// running CRC-16 CCITT over received bytes, one byte per enabled cycle, restarted by clear
`default_nettype none

module ocd_crc16 (
    input  wire                            clk,
    input  wire                            reset_n,
    input  wire                            clear,
    input  wire                            en,
    input  wire [ocd_pkg::DATA_WIDTH-1:0]  data_in,
    output logic [15:0]                    crc
);

    logic [15:0] base;
    logic [15:0] next_crc;

    // clear wins over the held value, a byte taken with it starts the new run
    always_comb begin
        base = clear ? ocd_pkg::CRC_INIT : crc;
        next_crc = base;
        for (int i = ocd_pkg::DATA_WIDTH - 1; i >= 0; i--) begin
            if (next_crc[15] ^ data_in[i]) begin
                next_crc = {next_crc[14:0], 1'b0} ^ ocd_pkg::CRC_POLY;
            end else begin
                next_crc = {next_crc[14:0], 1'b0};
            end
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            crc <= ocd_pkg::CRC_INIT;
        end else if (en) begin
            crc <= next_crc;
        end else if (clear) begin
            crc <= ocd_pkg::CRC_INIT;
        end
    end

endmodule

`default_nettype wire

/* frame_rx/ocd_frame_rx.sv */
// hunts for the sync pattern, collects frame fields and passes on frames with a zero CRC residue
`default_nettype none

module ocd_frame_rx (
    input  wire                            clk,
    input  wire                            reset_n,
    input  wire                            rx_valid,
    input  wire [ocd_pkg::DATA_WIDTH-1:0]  rx_byte,
    output logic                           frame_valid,
    output ocd_pkg::frame_t                frame
);

    localparam int DW         = ocd_pkg::DATA_WIDTH;
    localparam int BODY_LEN   = ocd_pkg::FRAME_LEN - ocd_pkg::SYNC_LEN;
    localparam int FIELD_BITS = $bits(ocd_pkg::frame_t);
    localparam int FIELD_LEN  = FIELD_BITS / DW;
    localparam int CNT_WIDTH  = $clog2(BODY_LEN);

    typedef enum logic [1:0] {S_HUNT, S_SYNC_1, S_SYNC_2, S_BODY} state_t;

    state_t                 state;
    logic [CNT_WIDTH-1:0]   byte_cnt;
    logic [FIELD_BITS-1:0]  field_sr;
    logic                   check;
    logic                   sync_hit;
    logic                   last_byte;
    logic                   crc_clear;
    logic [15:0]            crc;

    // compare against the sync byte expected in this state
    always_comb begin
        case (state)
            S_SYNC_1: sync_hit = rx_byte == ocd_pkg::SYNC_PATTERN[2*DW-1 -: DW];
            S_SYNC_2: sync_hit = rx_byte == ocd_pkg::SYNC_PATTERN[DW-1 -: DW];
            default:  sync_hit = rx_byte == ocd_pkg::SYNC_PATTERN[3*DW-1 -: DW];
        endcase
    end

    assign last_byte = byte_cnt == CNT_WIDTH'(BODY_LEN - 1);

    // held cleared while hunting, so the first sync byte starts a fresh CRC
    assign crc_clear = state == S_HUNT;

    ocd_crc16 u_crc16 (
        .clk     (clk),
        .reset_n (reset_n),
        .clear   (crc_clear),
        .en      (rx_valid),
        .data_in (rx_byte),
        .crc     (crc)
    );

    ////////////////////////////////////////////////////////////////////////////
    // frame FSM
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state       <= S_HUNT;
            byte_cnt    <= '0;
            check       <= 1'b0;
            frame_valid <= 1'b0;
        end else begin
            // residue is read one cycle after the last CRC byte went in
            frame_valid <= check && (crc == 16'h0000);
            check       <= 1'b0;
            if (rx_valid) begin
                case (state)
                    S_HUNT: begin
                        if (sync_hit) begin
                            state <= S_SYNC_1;
                        end
                    end
                    S_SYNC_1: begin
                        state <= sync_hit ? S_SYNC_2 : S_HUNT;
                    end
                    S_SYNC_2: begin
                        state    <= sync_hit ? S_BODY : S_HUNT;
                        byte_cnt <= '0;
                    end
                    default: begin
                        byte_cnt <= byte_cnt + CNT_WIDTH'(1);
                        if (last_byte) begin
                            state <= S_HUNT;
                            check <= 1'b1;
                        end
                    end
                endcase
            end
        end
    end

    // type, address and data bytes only, the CRC bytes are not kept
    always_ff @(posedge clk) begin
        if (rx_valid && state == S_BODY && byte_cnt < CNT_WIDTH'(FIELD_LEN)) begin
            field_sr <= {field_sr[FIELD_BITS-DW-1:0], rx_byte};
        end
    end

    assign frame = ocd_pkg::frame_t'(field_sr);

endmodule

`default_nettype wire

/* source/ocd_cmd_ctrl.sv */
// decodes accepted frames into program memory, CPU and status commands and runs the handshakes
`default_nettype none

module ocd_cmd_ctrl (
    input  wire                              clk,
    input  wire                              reset_n,
    input  wire                              frame_valid,
    input  wire ocd_pkg::frame_t             frame,
    input  wire [ocd_pkg::PC_WIDTH-1:0]      pc,
    input  wire                              stall,
    output logic                             pram_wr_en,
    output logic [ocd_pkg::ADDR_WIDTH-3:0]   pram_wr_addr,
    output logic [ocd_pkg::WORD_WIDTH-1:0]   pram_wr_data,
    output logic                             pram_rd_req,
    output logic [ocd_pkg::ADDR_WIDTH-1:0]   pram_rd_addr,
    input  wire                              pram_rd_ack,
    input  wire [ocd_pkg::WORD_WIDTH-1:0]    pram_rd_data,
    output ocd_pkg::cpu_cmd_t                cpu_cmd,
    output logic                             reply_req,
    output ocd_pkg::reply_t                  reply,
    input  wire                              reply_ack
);

    typedef enum logic [2:0] {
        S_IDLE, S_WR_ACK, S_RD_WAIT, S_RD_END, S_REPLY, S_REPLY_END
    } state_t;

    state_t             state;
    logic               accept;
    logic               is_write;
    logic               write_ack;
    logic               is_read;
    logic               is_status;
    logic               is_ctrl;
    ocd_pkg::cpu_cmd_t  cmd;

    // frames that arrive while busy are dropped
    assign accept = (state == S_IDLE) && frame_valid;

    ////////////////////////////////////////////////////////////////////////////
    // type decode
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        is_write  = 1'b0;
        write_ack = 1'b0;
        is_read   = 1'b0;
        is_status = 1'b0;
        cmd       = '0;
        cmd.break_a = frame.addr[ocd_pkg::PC_WIDTH-1:0];
        cmd.break_b = frame.data[ocd_pkg::PC_WIDTH-1:0];
        case (frame.frame_type)
            ocd_pkg::FT_PRAM_WRITE_NOACK: is_write = 1'b1;
            ocd_pkg::FT_PRAM_WRITE_ACK: begin
                is_write  = 1'b1;
                write_ack = 1'b1;
            end
            ocd_pkg::FT_PRAM_READ:   is_read       = 1'b1;
            ocd_pkg::FT_PAUSE_ON:    cmd.pause_on  = 1'b1;
            ocd_pkg::FT_PAUSE_OFF:   cmd.pause_off = 1'b1;
            ocd_pkg::FT_BREAK_ON:    cmd.break_on  = 1'b1;
            ocd_pkg::FT_BREAK_OFF:   cmd.break_off = 1'b1;
            ocd_pkg::FT_RUN_PULSE:   cmd.run       = 1'b1;
            ocd_pkg::FT_READ_STATUS: is_status     = 1'b1;
            default: ;
        endcase
        is_ctrl = cmd.pause_on | cmd.pause_off | cmd.break_on | cmd.break_off | cmd.run;
    end

    ////////////////////////////////////////////////////////////////////////////
    // control FSM and handshakes
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state       <= S_IDLE;
            pram_wr_en  <= 1'b0;
            pram_rd_req <= 1'b0;
            reply_req   <= 1'b0;
            cpu_cmd     <= '0;
        end else begin
            pram_wr_en <= 1'b0;
            cpu_cmd    <= '0;
            case (state)
                S_IDLE: begin
                    if (frame_valid) begin
                        pram_wr_en  <= is_write;
                        pram_rd_req <= is_read;
                        cpu_cmd     <= cmd;
                        reply_req   <= is_ctrl | is_status;
                        if (write_ack) begin
                            state <= S_WR_ACK;
                        end else if (is_read) begin
                            state <= S_RD_WAIT;
                        end else if (is_ctrl | is_status) begin
                            state <= S_REPLY;
                        end
                    end
                end
                // write ack replies one cycle behind the write strobe
                S_WR_ACK: begin
                    reply_req <= 1'b1;
                    state     <= S_REPLY;
                end
                S_RD_WAIT: begin
                    if (pram_rd_ack) begin
                        pram_rd_req <= 1'b0;
                        state       <= S_RD_END;
                    end
                end
                S_RD_END: begin
                    if (!pram_rd_ack) begin
                        reply_req <= 1'b1;
                        state     <= S_REPLY;
                    end
                end
                S_REPLY: begin
                    if (reply_ack) begin
                        reply_req <= 1'b0;
                        state     <= S_REPLY_END;
                    end
                end
                default: begin
                    if (!reply_ack) begin
                        state <= S_IDLE;
                    end
                end
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // memory address, write data and reply payload
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (accept) begin
            pram_wr_addr <= frame.addr[ocd_pkg::ADDR_WIDTH-1:2];
            pram_wr_data <= frame.data;
            pram_rd_addr <= frame.addr;
            reply.payload.frame_type <= frame.frame_type;
            reply.payload.toggle     <= frame.toggle;
            if (is_status) begin
                reply.op <= ocd_pkg::op_t'(1 << ocd_pkg::OP_STATUS);
                reply.payload.addr <= {{(ocd_pkg::ADDR_WIDTH - 1){1'b0}}, stall};
                reply.payload.data <= {{(ocd_pkg::WORD_WIDTH - ocd_pkg::PC_WIDTH){1'b0}}, pc};
            end else begin
                reply.op <= is_read ? ocd_pkg::op_t'(1 << ocd_pkg::OP_READ_BACK)
                                    : ocd_pkg::op_t'(1 << ocd_pkg::OP_ACK);
                reply.payload.addr <= frame.addr;
                reply.payload.data <= ocd_pkg::ACK_SIGNATURE;
            end
        end else if (state == S_RD_WAIT && pram_rd_ack) begin
            // memory word is valid only while the ack is high
            reply.payload.data <= pram_rd_data;
        end
    end

endmodule

`default_nettype wire

/* source/ocd_cpu_ctrl.sv */
// holds pause, breakpoint and single-step state driven into the CPU from command strobes
`default_nettype none

module ocd_cpu_ctrl (
    input  wire                           clk,
    input  wire                           reset_n,
    input  wire ocd_pkg::cpu_cmd_t        cpu_cmd,
    output logic                          pause,
    output logic                          break_on,
    output logic                          run_pulse,
    output logic [ocd_pkg::PC_WIDTH-1:0]  break_addr_a,
    output logic [ocd_pkg::PC_WIDTH-1:0]  break_addr_b
);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            pause     <= 1'b0;
            break_on  <= 1'b0;
            run_pulse <= 1'b0;
        end else begin
            // strobe lasts one cycle, so the pulse does too
            run_pulse <= cpu_cmd.run;

            if (cpu_cmd.pause_on) begin
                pause <= 1'b1;
            end else if (cpu_cmd.pause_off) begin
                pause <= 1'b0;
            end

            if (cpu_cmd.break_on) begin
                break_on <= 1'b1;
            end else if (cpu_cmd.break_off) begin
                break_on <= 1'b0;
            end
        end
    end

    // addresses survive break off
    always_ff @(posedge clk) begin
        if (cpu_cmd.break_on) begin
            break_addr_a <= cpu_cmd.break_a;
            break_addr_b <= cpu_cmd.break_b;
        end
    end

endmodule

`default_nettype wire

/* source/ocd_top.sv */
// top level of the debug receiver, a straight pipeline of frame receiver, command and CPU control
`default_nettype none

module ocd_top (
    input  wire                              clk,
    input  wire                              reset_n,
    input  wire                              rx_valid,
    input  wire [ocd_pkg::DATA_WIDTH-1:0]    rx_byte,
    input  wire [ocd_pkg::PC_WIDTH-1:0]      pc,
    input  wire                              stall,
    output logic                             pram_wr_en,
    output logic [ocd_pkg::ADDR_WIDTH-3:0]   pram_wr_addr,
    output logic [ocd_pkg::WORD_WIDTH-1:0]   pram_wr_data,
    output logic                             pram_rd_req,
    output logic [ocd_pkg::ADDR_WIDTH-1:0]   pram_rd_addr,
    input  wire                              pram_rd_ack,
    input  wire [ocd_pkg::WORD_WIDTH-1:0]    pram_rd_data,
    output logic                             reply_req,
    output ocd_pkg::reply_t                  reply,
    input  wire                              reply_ack,
    output logic                             pause,
    output logic                             break_on,
    output logic                             run_pulse,
    output logic [ocd_pkg::PC_WIDTH-1:0]     break_addr_a,
    output logic [ocd_pkg::PC_WIDTH-1:0]     break_addr_b
);

    logic               frame_valid;
    ocd_pkg::frame_t    frame;
    ocd_pkg::cpu_cmd_t  cpu_cmd;

    ocd_frame_rx u_frame_rx (
        .clk         (clk),
        .reset_n     (reset_n),
        .rx_valid    (rx_valid),
        .rx_byte     (rx_byte),
        .frame_valid (frame_valid),
        .frame       (frame)
    );

    ocd_cmd_ctrl u_cmd_ctrl (
        .clk          (clk),
        .reset_n      (reset_n),
        .frame_valid  (frame_valid),
        .frame        (frame),
        .pc           (pc),
        .stall        (stall),
        .pram_wr_en   (pram_wr_en),
        .pram_wr_addr (pram_wr_addr),
        .pram_wr_data (pram_wr_data),
        .pram_rd_req  (pram_rd_req),
        .pram_rd_addr (pram_rd_addr),
        .pram_rd_ack  (pram_rd_ack),
        .pram_rd_data (pram_rd_data),
        .cpu_cmd      (cpu_cmd),
        .reply_req    (reply_req),
        .reply        (reply),
        .reply_ack    (reply_ack)
    );

    ocd_cpu_ctrl u_cpu_ctrl (
        .clk          (clk),
        .reset_n      (reset_n),
        .cpu_cmd      (cpu_cmd),
        .pause        (pause),
        .break_on     (break_on),
        .run_pulse    (run_pulse),
        .break_addr_a (break_addr_a),
        .break_addr_b (break_addr_b)
    );

endmodule

`default_nettype wire

/* test/ocd_checker.sv */
// testbench checker for ocd_top, decodes the byte stream itself and compares DUT outputs per test
`default_nettype none

module ocd_checker (
    input  wire                               clk,
    input  wire                               reset_n,
    input  wire                               rx_valid,
    input  wire [ocd_pkg::DATA_WIDTH-1:0]     rx_byte,
    input  wire [ocd_pkg::PC_WIDTH-1:0]       pc,
    input  wire                               stall,
    input  wire                               pram_wr_en,
    input  wire [ocd_pkg::ADDR_WIDTH-3:0]     pram_wr_addr,
    input  wire [ocd_pkg::WORD_WIDTH-1:0]     pram_wr_data,
    input  wire                               pram_rd_req,
    input  wire [ocd_pkg::ADDR_WIDTH-1:0]     pram_rd_addr,
    input  wire                               pram_rd_ack,
    input  wire [ocd_pkg::WORD_WIDTH-1:0]     pram_rd_data,
    input  wire                               reply_req,
    input  wire ocd_pkg::reply_t              reply,
    input  wire                               pause,
    input  wire                               break_on,
    input  wire                               run_pulse,
    input  wire [ocd_pkg::PC_WIDTH-1:0]       break_addr_a,
    input  wire [ocd_pkg::PC_WIDTH-1:0]       break_addr_b,
    input  wire                               test_end,
    input  wire [7:0]                         test_id,
    input  wire                               run_done,
    output int                                errors
);
    timeunit 1ns;
    timeprecision 100ps;

    logic [7:0]       fb [0:11];
    int               pos;
    ocd_pkg::frame_t  exp_frame;
    logic             exp_wr, exp_rd, exp_reply, got_wr, got_reply, prev_req, prev_rd;
    logic             exp_pause, exp_break, break_loaded;
    logic [15:0]      exp_addr_a, exp_addr_b;
    logic [31:0]      rd_word;
    int               exp_runs, runs_seen, start_errors, tests_run, tests_failed;

    function automatic logic [15:0] frame_crc(input int n);
        logic [15:0] c;
        c = ocd_pkg::CRC_INIT;
        for (int i = 0; i < n; i++) begin
            for (int b = 7; b >= 0; b--) begin
                c = (c[15] ^ fb[i][b]) ? ({c[14:0], 1'b0} ^ 16'h1021) : {c[14:0], 1'b0};
            end
        end
        return c;
    endfunction

    // reply as the frame rules define it
    function automatic ocd_pkg::reply_t expected_reply(input ocd_pkg::frame_t f,
            input logic [15:0] pc_v, input logic stall_v, input logic [31:0] word);
        ocd_pkg::reply_t r;
        r.payload = f;
        r.op = 3'b001;
        r.payload.data = 32'hAAABACAD;
        if (f.frame_type == 7'd3) begin
            r.op = 3'b010;
            r.payload.data = word;
        end else if (f.frame_type == 7'd9) begin
            r.op = 3'b100;
            r.payload.addr = {15'd0, stall_v};
            r.payload.data = {16'd0, pc_v};
        end
        return r;
    endfunction

    task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] got);
        if (exp !== got) begin
            $display("Error: %s expected %h got %h", name, exp, got);
            errors++;
        end
    endtask

    task automatic report(input string what);
        $display("test %0d: %s", test_id, what);
        errors++;
    endtask

    initial begin
        errors = 0;
        pos = 0;
        exp_wr = 0;
        exp_rd = 0;
        exp_reply = 0;
        got_wr = 0;
        got_reply = 0;
        prev_req = 0;
        prev_rd = 0;
        exp_pause = 0;
        exp_break = 0;
        break_loaded = 0;
        exp_runs = 0;
        runs_seen = 0;
        start_errors = 0;
        tests_run = 0;
        tests_failed = 0;
    end

    always @(posedge clk) begin
        if (reset_n) begin
            ////////////////////////////////////////////////////////////////////////////
            // frame decode from the byte stream
            ////////////////////////////////////////////////////////////////////////////
            if (rx_valid) begin
                if (pos < 3) begin
                    if (rx_byte == ocd_pkg::SYNC_PATTERN[23-8*pos -: 8]) begin
                        fb[pos] = rx_byte;
                        pos++;
                    end else begin
                        pos = 0;
                    end
                end else begin
                    fb[pos] = rx_byte;
                    pos++;
                end
                if (pos == 12) begin
                    pos = 0;
                    if (frame_crc(12) == 16'h0000) begin
                        exp_frame = ocd_pkg::frame_t'({fb[3], fb[4], fb[5], fb[6],
                                                       fb[7], fb[8], fb[9]});
                        exp_wr    = exp_frame.frame_type inside {7'd1, 7'd2};
                        exp_rd    = exp_frame.frame_type == 7'd3;
                        exp_reply = exp_frame.frame_type inside {[7'd2:7'd9]};
                        case (exp_frame.frame_type)
                            7'd4: exp_pause = 1;
                            7'd5: exp_pause = 0;
                            7'd6: begin
                                exp_break = 1;
                                break_loaded = 1;
                                exp_addr_a = exp_frame.addr;
                                exp_addr_b = exp_frame.data[15:0];
                            end
                            7'd7: exp_break = 0;
                            7'd8: exp_runs = 1;
                            default: ;
                        endcase
                    end
                end
            end

            ////////////////////////////////////////////////////////////////////////////
            // output compares
            ////////////////////////////////////////////////////////////////////////////
            if (pram_wr_en) begin
                if (!exp_wr || got_wr) report("unexpected program memory write");
                check_value("pram_wr_addr", 64'(exp_frame.addr[15:2]), 64'(pram_wr_addr));
                check_value("pram_wr_data", 64'(exp_frame.data), 64'(pram_wr_data));
                got_wr = 1;
            end
            if (pram_rd_req && !prev_rd) begin
                if (!exp_rd) report("unexpected program memory read");
                check_value("pram_rd_addr", 64'(exp_frame.addr), 64'(pram_rd_addr));
            end
            if (pram_rd_ack) rd_word = pram_rd_data;
            if (reply_req && !prev_req) begin
                if (!exp_reply || got_reply) report("reply sent for a frame that needs none");
                check_value("reply", 64'(expected_reply(exp_frame, pc, stall, rd_word)),
                            64'(reply));
                got_reply = 1;
            end
            if (run_pulse) runs_seen++;
            prev_req = reply_req;
            prev_rd = pram_rd_req;

            if (test_end) begin
                if (exp_wr && !got_wr) report("program memory write missing");
                if (exp_reply && !got_reply) report("reply missing");
                check_value("run_pulse cycles", 64'(exp_runs), 64'(runs_seen));
                check_value("pause", 64'(exp_pause), 64'(pause));
                check_value("break_on", 64'(exp_break), 64'(break_on));
                if (break_loaded) begin
                    check_value("break_addr_a", 64'(exp_addr_a), 64'(break_addr_a));
                    check_value("break_addr_b", 64'(exp_addr_b), 64'(break_addr_b));
                end
                tests_run++;
                if (errors != start_errors) tests_failed++;
                $display("test %0d %s", test_id, (errors == start_errors) ? "ok" : "failed");
                start_errors = errors;
                exp_wr = 0;
                exp_rd = 0;
                exp_reply = 0;
                got_wr = 0;
                got_reply = 0;
                exp_runs = 0;
                runs_seen = 0;
            end
        end
    end

    always @(posedge run_done) begin
        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
    end

endmodule

`default_nettype wire

/* test/tb_ocd_top.sv */
// testbench top for ocd_top, builds frames, models program memory and the reply host, runs tests
`default_nettype none

module tb_ocd_top;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_FRAMES = 14;
    localparam int MAX_GAP    = 3;
    localparam int MAX_DELAY  = 5;
    localparam int SETTLE     = 20;
    localparam int REPLY_WAIT = SETTLE + 2 * MAX_DELAY;
    // twice the byte time of every frame, plus handshakes and settling per test
    localparam int LIMIT = 2 * NUM_FRAMES * 12 * (MAX_GAP + 1)
                         + NUM_FRAMES * (4 * MAX_DELAY + SETTLE + 20) + 20;

    logic clk, reset_n, rx_valid, stall, pram_rd_ack, reply_ack;
    logic [7:0] rx_byte;
    logic [15:0] pc;
    logic [31:0] pram_rd_data;
    logic pram_wr_en, pram_rd_req, reply_req, pause, break_on, run_pulse;
    logic [13:0] pram_wr_addr;
    logic [31:0] pram_wr_data;
    logic [15:0] pram_rd_addr, break_addr_a, break_addr_b;
    ocd_pkg::reply_t reply;
    logic test_end, run_done;
    logic [7:0] test_id;
    int errors, cycles;
    integer seed;
    logic [31:0] mem [0:16383];

    ocd_top ocd_top_i (.*);

    ocd_checker chk (.*);

    initial begin
        clk = 0;
        forever #50 clk = ~clk;
    end

    function automatic logic [15:0] crc16_ref(input logic [7:0] b [0:11], input int n);
        logic [15:0] c;
        c = 16'hFFFF;
        for (int i = 0; i < n; i++) begin
            for (int k = 7; k >= 0; k--) begin
                c = (c[15] ^ b[i][k]) ? ({c[14:0], 1'b0} ^ 16'h1021) : {c[14:0], 1'b0};
            end
        end
        return c;
    endfunction

    task automatic send_frame(input logic [6:0] ft, input logic tog, input logic [15:0] addr,
            input logic [31:0] data, input logic bad_crc, input logic bad_sync);
        logic [7:0] b [0:11];
        logic [15:0] c;
        int gap;
        {b[0], b[1], b[2]} = 24'h5AA596;
        b[3] = {ft, tog};
        {b[4], b[5]} = addr;
        {b[6], b[7], b[8], b[9]} = data;
        c = crc16_ref(b, 10);
        {b[10], b[11]} = c;
        if (bad_crc) b[11] = b[11] ^ 8'h01;
        if (bad_sync) b[1] = b[1] ^ 8'hFF;
        for (int i = 0; i < 12; i++) begin
            rx_valid = 1;
            rx_byte = b[i];
            @(posedge clk);
            #1 rx_valid = 0;
            gap = {$random(seed)} % (MAX_GAP + 1);
            repeat (gap) begin
                @(posedge clk);
                #1;
            end
        end
    endtask

    task automatic run_test(input logic [6:0] ft, input logic [15:0] addr,
            input logic [31:0] data, input logic bad_crc, input logic bad_sync,
            input logic with_reply);
        int waited;
        test_id = test_id + 1;
        send_frame(ft, test_id[0], addr, data, bad_crc, bad_sync);
        if (with_reply) begin
            // give up on a reply after REPLY_WAIT cycles
            waited = 0;
            while (!reply_req && waited < REPLY_WAIT) begin
                @(posedge clk);
                #1;
                waited++;
            end
            while (reply_req || reply_ack) begin
                @(posedge clk);
                #1;
            end
            repeat (4) @(posedge clk);
        end else begin
            repeat (SETTLE) @(posedge clk);
        end
        #1 test_end = 1;
        @(posedge clk);
        #1 test_end = 0;
    endtask

    // program memory model, fill pattern from the full word address
    initial begin
        for (int i = 0; i < 16384; i++) begin
            mem[i] = {i[13:0], 2'b01, ~i[13:0], 2'b10};
        end
        forever begin
            @(posedge clk);
            if (pram_rd_req) begin
                repeat ({$random(seed)} % (MAX_DELAY + 1)) @(posedge clk);
                #1 pram_rd_data = mem[pram_rd_addr[15:2]];
                pram_rd_ack = 1;
                do @(posedge clk); while (pram_rd_req);
                #1 pram_rd_ack = 0;
            end
        end
    end

    always @(posedge clk) begin
        if (pram_wr_en) mem[pram_wr_addr] <= pram_wr_data;
    end

    // reply host
    initial begin
        forever begin
            @(posedge clk);
            if (reply_req) begin
                repeat ({$random(seed)} % (MAX_DELAY + 1)) @(posedge clk);
                #1 reply_ack = 1;
                do @(posedge clk); while (reply_req);
                #1 reply_ack = 0;
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", LIMIT);
            $display("Finished with errors");
            $finish;
        end
    end

    initial begin
        seed = 32'hc62a;
        cycles = 0;
        reset_n = 0;
        rx_valid = 0;
        rx_byte = 0;
        pc = 16'h4321;
        stall = 1;
        pram_rd_ack = 0;
        pram_rd_data = 0;
        reply_ack = 0;
        test_end = 0;
        run_done = 0;
        test_id = 0;
        repeat (10) @(posedge clk);
        #1 reset_n = 1;
        repeat (2) @(posedge clk);
        #1;
        run_test(7'd2, 16'h0124, 32'h11223344, 0, 0, 1);
        run_test(7'd1, 16'h0208, 32'h55667788, 0, 0, 0);
        run_test(7'd1, 16'h030C, 32'h99AABBCC, 1, 0, 0);
        run_test(7'd1, 16'h0310, 32'hDDEEFF00, 0, 1, 0);
        run_test(7'd3, 16'h0124, 32'h0, 0, 0, 1);
        run_test(7'd3, 16'h3FFC, 32'h0, 0, 0, 1);
        run_test(7'd4, 16'h0000, 32'h0, 0, 0, 1);
        run_test(7'd6, 16'h1234, 32'h0000ABCD, 0, 0, 1);
        run_test(7'd7, 16'h0000, 32'h0, 0, 0, 1);
        run_test(7'd5, 16'h0000, 32'h0, 0, 0, 1);
        run_test(7'd8, 16'h0000, 32'h0, 0, 0, 1);
        run_test(7'd9, 16'h0000, 32'h0, 0, 0, 1);
        // status again with other pc and stall values
        pc = 16'h8A3C;
        stall = 0;
        run_test(7'd9, 16'h0000, 32'h0, 0, 0, 1);
        run_test(7'h50, 16'h0044, 32'h12345678, 0, 0, 0);
        run_done = 1;
        @(posedge clk);
        #1;
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* ocd_top.f */
common/ocd_pkg.sv
frame_rx/ocd_crc16.sv
frame_rx/ocd_frame_rx.sv
source/ocd_cmd_ctrl.sv
source/ocd_cpu_ctrl.sv
source/ocd_top.sv
test/ocd_checker.sv
test/tb_ocd_top.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        := tb_ocd_top
RTL_TOP    := ocd_top
FILELIST   := ocd_top.f
FLAGS      := --binary --timing -Wno-fatal -j 0
LINT_FLAGS := --lint-only --timing -Wall
LOG        := sim.log
OBJ_DIR    := obj_dir

.PHONY: all run lint clean

all: run

$(OBJ_DIR)/V$(TOP): $(shell cat $(FILELIST))
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^Finished with no errors$$" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) \
		common/ocd_pkg.sv frame_rx/ocd_crc16.sv frame_rx/ocd_frame_rx.sv \
		source/ocd_cmd_ctrl.sv source/ocd_cpu_ctrl.sv source/ocd_top.sv

clean:
	rm -rf $(OBJ_DIR) $(LOG)
